// ==== hdl/lcd_pkg.sv ====
package lcd_pkg;

	// clock cycles per microsecond
	localparam int CLK_MHZ = 15;

	// panel timing in microseconds
	localparam int POWER_UP_US = 500;
	localparam int E_SETUP_US = 1;
	localparam int E_HIGH_US = 14;
	localparam int WRITE_US = 50;
	localparam int INIT_PULSE_US = 10;
	localparam int INIT_WAIT_FUNC_US = 50;
	localparam int INIT_WAIT_DISP_US = 50;
	localparam int INIT_WAIT_CLEAR_US = 200;
	localparam int INIT_WAIT_ENTRY_US = 100;

	localparam int CNT_BITS = 14; // fits 7500 cycles of power-up

	// same windows in clock cycles
	localparam logic [CNT_BITS-1:0] POWER_UP_CYC = CNT_BITS'(POWER_UP_US * CLK_MHZ);
	localparam logic [CNT_BITS-1:0] INIT_PULSE_CYC = CNT_BITS'(INIT_PULSE_US * CLK_MHZ);
	localparam logic [CNT_BITS-1:0] E_ON_CYC = CNT_BITS'(E_SETUP_US * CLK_MHZ);
	localparam logic [CNT_BITS-1:0] E_OFF_CYC = CNT_BITS'(E_HIGH_US * CLK_MHZ);
	localparam logic [CNT_BITS-1:0] WRITE_CYC = CNT_BITS'(WRITE_US * CLK_MHZ);

	// HD44780 command base codes
	localparam logic [7:0] CMD_FUNCTION_SET = 8'h30;
	localparam logic [7:0] CMD_DISPLAY_CTRL = 8'h08;
	localparam logic [7:0] CMD_CLEAR = 8'h01;
	localparam logic [7:0] CMD_ENTRY_MODE = 8'h04;
	localparam logic [7:0] CMD_SET_DDRAM = 8'h80;

	localparam logic [7:0] LINE2_ADDR = 8'h40; // ddram start of line 2
	localparam int LINE_CHARS = 16;
	localparam int BUF_CHARS = 32;

	// msb first, lines down to shift
	typedef struct packed {
		logic lines;      // 1 = two-line display
		logic font;       // 1 = 5x10 dots
		logic display_on;
		logic cursor;
		logic blink;
		logic inc_dec;    // 1 = increment address
		logic shift;      // display shift on write
	} lcd_config_t;

endpackage

// ==== hdl/lcd_bus_if.sv ====
`timescale 1ns/1ps

// one write request from the text writer to the controller
interface lcd_bus_if;
	logic enable;     // one-cycle request, only while busy is low
	logic rs;         // 0 = command, 1 = character
	logic [7:0] data;
	logic busy;       // high through init and each write cycle

	modport requester(
		output enable,
		output rs,
		output data,
		input busy
	);

	modport executor(
		input enable,
		input rs,
		input data,
		output busy
	);

endinterface

// ==== hdl/lcd_controller.sv ====
`timescale 1ns/1ps

module lcd_controller (
	input logic clk,
	input logic rst,
	input lcd_pkg::lcd_config_t config_word,
	lcd_bus_if.executor bus,
	output logic lcd_e,
	output logic lcd_rs,
	output logic lcd_rw,
	output logic [7:0] lcd_data
);

	typedef enum logic [1:0] {
		S_POWER_UP,
		S_INIT,
		S_IDLE,
		S_WRITE
	} state_t;

	state_t state;
	logic [lcd_pkg::CNT_BITS-1:0] cnt;      // cycle index within current window
	logic [lcd_pkg::CNT_BITS-1:0] cnt_next;
	logic [1:0] step;                        // init command index
	lcd_pkg::lcd_config_t cfg_q;             // config taken at first init command
	logic busy_q;

	assign cnt_next = cnt + 1'b1;
	assign bus.busy = busy_q;

	// init command byte for a given step
	function automatic logic [7:0] init_cmd(
		input logic [1:0] idx,
		input lcd_pkg::lcd_config_t cfg
	);
		case (idx)
			2'd0: init_cmd = lcd_pkg::CMD_FUNCTION_SET | {4'b0, cfg.lines, cfg.font, 2'b0};
			2'd1: init_cmd = lcd_pkg::CMD_DISPLAY_CTRL |
				{5'b0, cfg.display_on, cfg.cursor, cfg.blink};
			2'd2: init_cmd = lcd_pkg::CMD_CLEAR;
			default: init_cmd = lcd_pkg::CMD_ENTRY_MODE | {6'b0, cfg.inc_dec, cfg.shift};
		endcase
	endfunction

	// last count of a step: pulse plus its wait, minus one
	function automatic logic [lcd_pkg::CNT_BITS-1:0] init_last(input logic [1:0] idx);
		int wait_us;
		case (idx)
			2'd0: wait_us = lcd_pkg::INIT_WAIT_FUNC_US;
			2'd1: wait_us = lcd_pkg::INIT_WAIT_DISP_US;
			2'd2: wait_us = lcd_pkg::INIT_WAIT_CLEAR_US;
			default: wait_us = lcd_pkg::INIT_WAIT_ENTRY_US;
		endcase
		init_last = lcd_pkg::CNT_BITS'((lcd_pkg::INIT_PULSE_US + wait_us) * lcd_pkg::CLK_MHZ - 1);
	endfunction

	// enable window of a write cycle
	function automatic logic write_e(input logic [lcd_pkg::CNT_BITS-1:0] count);
		write_e = (count >= lcd_pkg::E_ON_CYC) && (count < lcd_pkg::E_OFF_CYC);
	endfunction

	always_ff @(posedge clk) begin
		lcd_rw <= 1'b0; // no reads on this bus
		if (rst) begin
			state <= S_POWER_UP;
			cnt <= '0;
			step <= 2'd0;
			busy_q <= 1'b1;
			lcd_e <= 1'b0;
			lcd_rs <= 1'b0;
			lcd_data <= 8'h00;
		end else begin
			case (state)
				S_POWER_UP: begin
					if (cnt == lcd_pkg::POWER_UP_CYC - 1'b1) begin
						// panel settled, start function set
						state <= S_INIT;
						cnt <= '0;
						step <= 2'd0;
						cfg_q <= config_word;
						lcd_e <= 1'b1;
						lcd_data <= init_cmd(2'd0, config_word);
					end else begin
						cnt <= cnt_next;
					end
				end
				S_INIT: begin
					if (cnt == init_last(step)) begin
						cnt <= '0;
						if (step == 2'd3) begin
							state <= S_IDLE;
							busy_q <= 1'b0; // init done
						end else begin
							step <= step + 2'd1;
							lcd_e <= 1'b1;
							lcd_data <= init_cmd(step + 2'd1, cfg_q);
						end
					end else begin
						cnt <= cnt_next;
						if (cnt_next == lcd_pkg::INIT_PULSE_CYC) begin
							lcd_e <= 1'b0; // pulse over, start wait
							lcd_data <= 8'h00;
						end
					end
				end
				S_IDLE: begin
					if (bus.enable) begin
						state <= S_WRITE;
						busy_q <= 1'b1;
						lcd_rs <= bus.rs;
						lcd_data <= bus.data;
						cnt <= cnt_next;
						lcd_e <= write_e(cnt_next);
					end
				end
				S_WRITE: begin
					if (cnt == lcd_pkg::WRITE_CYC) begin
						// cycle complete, release the pins
						state <= S_IDLE;
						busy_q <= 1'b0;
						cnt <= '0;
						lcd_e <= 1'b0;
						lcd_rs <= 1'b0;
						lcd_data <= 8'h00;
					end else begin
						cnt <= cnt_next;
						lcd_e <= write_e(cnt_next);
					end
				end
				default: state <= S_POWER_UP;
			endcase
		end
	end

endmodule

// ==== hdl/lcd_text_writer.sv ====
`timescale 1ns/1ps

module lcd_text_writer (
	input logic clk,
	input logic rst,
	input logic char_we,
	input logic [4:0] char_addr,
	input logic [7:0] char_data,
	input logic refresh,
	output logic ready,
	lcd_bus_if.requester bus
);

	typedef enum logic [1:0] {
		W_DRAIN, // wait for busy to fall
		W_READY,
		W_SEND
	} wstate_t;

	localparam logic [5:0] LINE2_IDX = 6'(lcd_pkg::LINE_CHARS + 1);
	localparam logic [5:0] LAST_IDX = 6'(lcd_pkg::BUF_CHARS + 1);

	wstate_t state;
	logic [5:0] idx;        // 0..33 over the frame
	logic [4:0] char_idx;
	logic [7:0] char_mem [lcd_pkg::BUF_CHARS];
	logic is_cmd;

	assign ready = (state == W_READY);

	// host writes land only between frames
	always_ff @(posedge clk) begin
		if (char_we && ready) begin
			char_mem[char_addr] <= char_data;
		end
	end

	// skip the address command slots
	always_comb begin
		if (idx <= LINE2_IDX) begin
			char_idx = 5'(idx - 6'd1);
		end else begin
			char_idx = 5'(idx - 6'd2);
		end
	end

	assign is_cmd = (idx == 6'd0) || (idx == LINE2_IDX);

	always_comb begin
		if (idx == 6'd0) begin
			bus.data = lcd_pkg::CMD_SET_DDRAM; // line 1 starts at 0
		end else if (idx == LINE2_IDX) begin
			bus.data = lcd_pkg::CMD_SET_DDRAM | lcd_pkg::LINE2_ADDR;
		end else begin
			bus.data = char_mem[char_idx];
		end
	end

	assign bus.rs = !is_cmd;
	assign bus.enable = (state == W_SEND) && !bus.busy; // first free cycle

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= W_DRAIN; // busy is high until init ends
			idx <= 6'd0;
		end else begin
			case (state)
				W_DRAIN: begin
					if (!bus.busy) begin
						state <= W_READY;
					end
				end
				W_READY: begin
					if (refresh) begin
						state <= W_SEND;
						idx <= 6'd0;
					end
				end
				W_SEND: begin
					if (bus.enable) begin
						if (idx == LAST_IDX) begin
							state <= W_DRAIN; // last char, wait out its cycle
						end else begin
							idx <= idx + 6'd1;
						end
					end
				end
				default: state <= W_DRAIN;
			endcase
		end
	end

endmodule

// ==== hdl/lcd_display_top.sv ====
`timescale 1ns/1ps

module lcd_display_top (
	input logic clk,
	input logic rst,
	input lcd_pkg::lcd_config_t config_word,
	input logic char_we,
	input logic [4:0] char_addr,
	input logic [7:0] char_data,
	input logic refresh,
	output logic ready,
	output logic lcd_e,
	output logic lcd_rs,
	output logic lcd_rw,
	output logic [7:0] lcd_data
);

	// write requests from the text writer into the controller
	lcd_bus_if bus_i ();

	lcd_text_writer u_writer (
		.clk       (clk),
		.rst       (rst),
		.char_we   (char_we),
		.char_addr (char_addr),
		.char_data (char_data),
		.refresh   (refresh),
		.ready     (ready),
		.bus       (bus_i.requester)
	);

	// sole driver of the panel pins
	lcd_controller u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.config_word (config_word),
		.bus         (bus_i.executor),
		.lcd_e       (lcd_e),
		.lcd_rs      (lcd_rs),
		.lcd_rw      (lcd_rw),
		.lcd_data    (lcd_data)
	);

endmodule

// ==== test/lcd_panel_model.sv ====
`timescale 1ns/1ps

// passive panel model, records every enable pulse seen on the lcd pins
module lcd_panel_model #(
	parameter int MAX_PULSES = 80
) (
	input logic clk,
	input logic rst,
	input logic lcd_e,
	input logic lcd_rs,
	input logic lcd_rw,
	input logic [7:0] lcd_data
);

	int pulse_count;                // completed pulses since reset
	logic cap_rs [MAX_PULSES];
	logic cap_rw [MAX_PULSES];
	logic [7:0] cap_data [MAX_PULSES];
	logic cap_stable [MAX_PULSES];  // rs and data held while e high
	int cap_width [MAX_PULSES];     // cycles with e high
	int cap_space [MAX_PULSES];     // rise to previous rise, first from reset

	int cycle;
	int last_rise;
	int high_cnt;
	logic e_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			pulse_count <= 0;
			cycle <= 0;
			last_rise <= 0;
			high_cnt <= 0;
			e_q <= 1'b0;
		end else begin
			cycle <= cycle + 1;
			e_q <= lcd_e;
			if (pulse_count < MAX_PULSES) begin
				if (lcd_e && !e_q) begin
					// rising edge, take the bus values
					cap_rs[pulse_count] <= lcd_rs;
					cap_rw[pulse_count] <= lcd_rw;
					cap_data[pulse_count] <= lcd_data;
					cap_stable[pulse_count] <= 1'b1;
					cap_space[pulse_count] <= cycle - last_rise;
					last_rise <= cycle;
					high_cnt <= 1;
				end else if (lcd_e) begin
					high_cnt <= high_cnt + 1;
					if (lcd_rs !== cap_rs[pulse_count] || lcd_data !== cap_data[pulse_count]) begin
						cap_stable[pulse_count] <= 1'b0; // bus moved during the pulse
					end
				end else if (e_q) begin
					cap_width[pulse_count] <= high_cnt;
					pulse_count <= pulse_count + 1;
				end
			end
		end
	end

endmodule

// ==== test/tb_lcd_display.sv ====
`timescale 1ns/1ps

module tb_lcd_display;

	typedef enum logic [1:0] {
		TEXT_FIXED,
		TEXT_RANDOM,
		TEXT_SPACES
	} text_mode_t;

	typedef struct packed {
		logic [6:0] cfg;      // lines, font, display_on, cursor, blink, inc_dec, shift
		text_mode_t mode;
		logic spurious;       // refresh and char_we in the middle of a frame
		logic [4:0] upd_addr;
		logic [7:0] upd_char;
	} row_t;

	logic clk = 1'b0;
	logic rst;
	lcd_pkg::lcd_config_t config_word;
	logic char_we;
	logic [4:0] char_addr;
	logic [7:0] char_data;
	logic refresh;
	logic ready;
	logic lcd_e;
	logic lcd_rs;
	logic lcd_rw;
	logic [7:0] lcd_data;

	row_t table_rows [3];
	logic [7:0] exp_text [32]; // what the panel should show
	logic [31:0] rng_state;
	string fixed_text = "HD44780 display line two of text";

	always #5 clk = ~clk;

	lcd_display_top DUT (
		.clk         (clk),
		.rst         (rst),
		.config_word (config_word),
		.char_we     (char_we),
		.char_addr   (char_addr),
		.char_data   (char_data),
		.refresh     (refresh),
		.ready       (ready),
		.lcd_e       (lcd_e),
		.lcd_rs      (lcd_rs),
		.lcd_rw      (lcd_rw),
		.lcd_data    (lcd_data)
	);

	lcd_panel_model panel (
		.clk      (clk),
		.rst      (rst),
		.lcd_e    (lcd_e),
		.lcd_rs   (lcd_rs),
		.lcd_rw   (lcd_rw),
		.lcd_data (lcd_data)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s (got %0h, expected %0h)", $time, what,
				actual, expected);
			$display("Something failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("TIMEOUT at %0t: %s", $time, what);
		$display("Something failed");
		$fatal(1, "stopped on timeout");
	endtask

	task automatic wait_ready(input int limit, input string what);
		int n;
		n = 0;
		while (!ready && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!ready) report_timeout($sformatf("ready never rose %s", what));
	endtask

	// ready has to stay low until the model has seen target pulses
	task automatic wait_frame(input int target);
		int n;
		n = 0;
		while (panel.pulse_count < target && n < 30000) begin
			@(negedge clk);
			check_equal(ready, 1'b0, "ready low while the frame runs");
			n++;
		end
		if (panel.pulse_count < target) begin
			report_timeout($sformatf("only %0d of %0d enable pulses seen",
				panel.pulse_count, target));
		end
	endtask

	task automatic apply_reset(input logic [6:0] cfg);
		@(posedge clk);
		rst <= 1'b1;
		config_word <= lcd_pkg::lcd_config_t'(cfg);
		char_we <= 1'b0;
		refresh <= 1'b0;
		repeat (9) @(posedge clk);
		@(negedge clk);
		check_equal(lcd_e, 1'b0, "lcd_e low in reset");
		check_equal({lcd_rs, lcd_rw, lcd_data}, 10'h0, "rs, rw and data zero in reset");
		check_equal(ready, 1'b0, "ready low in reset");
		@(posedge clk);
		rst <= 1'b0;
		@(posedge clk); // first edge with reset released
		@(negedge clk);
		check_equal(lcd_e, 1'b0, "lcd_e low after reset");
		check_equal(ready, 1'b0, "ready low after reset");
	endtask

	task automatic check_init(input logic [6:0] cfg);
		logic [7:0] exp_cmd [4];
		exp_cmd[0] = 8'h30 | {4'b0, cfg[6], cfg[5], 2'b0};
		exp_cmd[1] = 8'h08 | {5'b0, cfg[4:2]};
		exp_cmd[2] = 8'h01;
		exp_cmd[3] = 8'h04 | {6'b0, cfg[1:0]};
		check_equal(panel.pulse_count, 4, "pulse count when init is done");
		check_equal(panel.cap_space[0] >= lcd_pkg::POWER_UP_US * lcd_pkg::CLK_MHZ, 1'b1,
			"power-up wait before first command");
		for (int i = 0; i < 4; i++) begin
			check_equal(panel.cap_data[i], exp_cmd[i], $sformatf("init command %0d", i));
			check_equal(panel.cap_rs[i], 1'b0, $sformatf("rs of init command %0d", i));
			check_equal(panel.cap_rw[i], 1'b0, $sformatf("rw of init command %0d", i));
			check_equal(panel.cap_width[i], lcd_pkg::INIT_PULSE_US * lcd_pkg::CLK_MHZ,
				$sformatf("width of init pulse %0d", i));
		end
	endtask

	task automatic write_char(input logic [4:0] addr, input logic [7:0] data);
		@(posedge clk);
		char_we <= 1'b1;
		char_addr <= addr;
		char_data <= data;
		@(posedge clk);
		char_we <= 1'b0;
	endtask

	task automatic load_text(input text_mode_t mode);
		for (int i = 0; i < 32; i++) begin
			case (mode)
				TEXT_FIXED: exp_text[i] = fixed_text[i];
				TEXT_RANDOM: begin
					rng_state = xorshift32(rng_state);
					exp_text[i] = rng_state[7:0];
				end
				default: exp_text[i] = 8'h20;
			endcase
			write_char(5'(i), exp_text[i]);
		end
	endtask

	task automatic send_refresh();
		@(posedge clk);
		refresh <= 1'b1;
		@(posedge clk);
		refresh <= 1'b0;
		@(negedge clk);
		check_equal(ready, 1'b0, "ready falls after refresh");
	endtask

	// both must be dropped by the writer while ready is low
	task automatic poke_while_busy();
		@(posedge clk);
		refresh <= 1'b1;
		char_we <= 1'b1;
		char_addr <= 5'd5;
		char_data <= 8'h7e;
		@(posedge clk);
		refresh <= 1'b0;
		char_we <= 1'b0;
	endtask

	task automatic check_frame(input int base);
		logic [7:0] exp_data;
		logic exp_rs;
		int p;
		for (int i = 0; i < 34; i++) begin
			p = base + i;
			if (i == 0) begin
				exp_rs = 1'b0;
				exp_data = 8'h80; // line 1 address
			end else if (i == 17) begin
				exp_rs = 1'b0;
				exp_data = 8'hc0;
			end else if (i < 17) begin
				exp_rs = 1'b1;
				exp_data = exp_text[i-1];
			end else begin
				exp_rs = 1'b1;
				exp_data = exp_text[i-2];
			end
			check_equal(panel.cap_rs[p], exp_rs, $sformatf("rs of frame write %0d", i));
			check_equal(panel.cap_data[p], exp_data, $sformatf("data of frame write %0d", i));
			check_equal(panel.cap_rw[p], 1'b0, $sformatf("rw of frame write %0d", i));
			check_equal(panel.cap_stable[p], 1'b1, $sformatf("bus held in write %0d", i));
			check_equal(panel.cap_width[p],
				(lcd_pkg::E_HIGH_US - lcd_pkg::E_SETUP_US) * lcd_pkg::CLK_MHZ,
				$sformatf("enable width of write %0d", i));
			check_equal(panel.cap_space[p] >= lcd_pkg::WRITE_US * lcd_pkg::CLK_MHZ + 1, 1'b1,
				$sformatf("spacing before write %0d", i));
		end
	endtask

	task automatic run_row(input int r);
		row_t row;
		row = table_rows[r];
		apply_reset(row.cfg);
		wait_ready(20000, "after initialization");
		check_init(row.cfg);
		load_text(row.mode);
		send_refresh();
		if (row.spurious) begin
			wait_frame(4 + 5);
			poke_while_busy();
		end
		wait_frame(4 + 34);
		wait_ready(2000, "after the first frame");
		check_equal(panel.pulse_count, 4 + 34, "writes in first frame");
		check_frame(4);
		repeat (800) @(negedge clk);
		check_equal(panel.pulse_count, 4 + 34, "no extra writes after the frame");
		check_equal(ready, 1'b1, "ready stays high when idle");
		// single character change
		write_char(row.upd_addr, row.upd_char);
		exp_text[row.upd_addr] = row.upd_char;
		send_refresh();
		wait_frame(4 + 68);
		wait_ready(2000, "after the second frame");
		check_equal(panel.pulse_count, 4 + 68, "writes in second frame");
		check_frame(4 + 34);
	endtask

	initial begin
		rst = 1'b1;
		config_word = '0;
		char_we = 1'b0;
		char_addr = 5'd0;
		char_data = 8'h00;
		refresh = 1'b0;
		rng_state = 32'hf372;
		table_rows[0] = '{cfg: 7'b1010010, mode: TEXT_FIXED, spurious: 1'b0,
			upd_addr: 5'd7, upd_char: 8'h21};
		table_rows[1] = '{cfg: 7'b0111101, mode: TEXT_RANDOM, spurious: 1'b1,
			upd_addr: 5'd20, upd_char: 8'h5a};
		table_rows[2] = '{cfg: 7'b1101011, mode: TEXT_SPACES, spurious: 1'b1,
			upd_addr: 5'd31, upd_char: 8'h41};
		for (int r = 0; r < 3; r++) begin
			run_row(r);
		end
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== filelist.f ====
hdl/lcd_pkg.sv
hdl/lcd_bus_if.sv
hdl/lcd_controller.sv
hdl/lcd_text_writer.sv
hdl/lcd_display_top.sv
test/lcd_panel_model.sv
test/tb_lcd_display.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the lcd display testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_lcd_display \
	-f filelist.f -o sim_lcd

status=0
output=$(./obj_dir/sim_lcd 2>&1) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qx "Everything OK"; then
	echo "simulation passed"
	exit 0
fi

echo "simulation did not pass"
exit 1
